// File: Bender.yml
package:
  name: eeprom_master

sources:
  # packages first, then the datapath blocks and the top level
  - verilog/eeprom_cmd_pkg.sv
  - verilog/i2c_bus_pkg.sv
  - verilog/scl_gen.sv
  - verilog/cond_gen.sv
  - verilog/byte_shifter.sv
  - verilog/eeprom_ctrl.sv
  - verilog/eeprom_master_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/eeprom_slave_model.sv
      - verif/tb_eeprom_master.sv

// File: build.f
verilog/eeprom_cmd_pkg.sv
verilog/i2c_bus_pkg.sv
verilog/scl_gen.sv
verilog/cond_gen.sv
verilog/byte_shifter.sv
verilog/eeprom_ctrl.sv
verilog/eeprom_master_top.sv
verif/tb_clock.sv
verif/eeprom_slave_model.sv
verif/tb_eeprom_master.sv

// File: verif/eeprom_slave_model.sv
`timescale 1ns/1ps

module eeprom_slave_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic nack_mode,
    output logic sda_pull,
    output logic proto_err
);
    import eeprom_cmd_pkg::*;
    import i2c_bus_pkg::*;

    typedef enum logic [2:0] {
        P_CTRL,
        P_ADDR,
        P_WDATA,
        P_READ,
        P_IGNORE
    } phase_e;

    logic [DATA_W-1:0] mem [0:2047];
    logic              scl_q;
    logic              sda_q;
    logic              busy;
    logic              first_fall;   // scl fall that ends a start
    logic              sending;
    logic              wr_pending;
    logic [3:0]        bit_cnt;
    logic [DATA_W-1:0] shreg;
    logic [DATA_W-1:0] tx;
    logic [2:0]        blk;
    logic [DATA_W-1:0] word;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    phase_e            phase;
    phase_e            next_phase;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'h5a;
    end

    task automatic flag_error(input cond_e kind, input string what);
        $display("slave model at %0t: %s (%s)", $time, what, kind.name());
        proto_err <= 1'b1;
    endtask

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            busy       <= 1'b0;
            first_fall <= 1'b0;
            sending    <= 1'b0;
            wr_pending <= 1'b0;
            bit_cnt    <= '0;
            sda_pull   <= 1'b0;
            proto_err  <= 1'b0;
            phase      <= P_IGNORE;
            next_phase <= P_IGNORE;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_q && scl && sda_q && !sda)
            begin
                // a restart is legal only right after the word address
                if (busy && !(phase == P_WDATA && bit_cnt == 0 && !first_fall))
                    flag_error(COND_START, "start without a stop before it");
                busy       <= 1'b1;
                first_fall <= 1'b1;
                bit_cnt    <= '0;
                sending    <= 1'b0;
                wr_pending <= 1'b0;
                phase      <= P_CTRL;
            end
            else if (scl_q && scl && !sda_q && sda)
            begin
                if (!busy || first_fall || bit_cnt != 0)
                    flag_error(COND_STOP, "stop outside a byte boundary");
                if (wr_pending)
                    mem[wr_addr] <= wr_data;   // write cycle on stop
                busy       <= 1'b0;
                wr_pending <= 1'b0;
                sda_pull   <= 1'b0;
            end
            else if (busy && !scl_q && scl)
            begin
                if (bit_cnt < 8)
                    shreg <= {shreg[DATA_W-2:0], sda};
            end
            else if (busy && scl_q && !scl)
            begin
                if (first_fall)
                    first_fall <= 1'b0;
                else if (bit_cnt < 7)
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (sending)
                        sda_pull <= !tx[6 - bit_cnt];
                end
                else if (bit_cnt == 7)
                begin
                    bit_cnt <= 4'd8;
                    if (sending)
                    begin
                        sda_pull   <= 1'b0;       // master answers here
                        next_phase <= P_IGNORE;
                    end
                    else
                    begin
                        case (phase)
                            P_CTRL:
                                if (shreg[7:4] == DEVICE_CODE && !nack_mode)
                                begin
                                    sda_pull   <= 1'b1;
                                    blk        <= shreg[3:1];
                                    next_phase <= shreg[0] ? P_READ : P_ADDR;
                                end
                                else
                                begin
                                    sda_pull   <= 1'b0;
                                    next_phase <= P_IGNORE;
                                end
                            P_ADDR:
                            begin
                                sda_pull   <= 1'b1;
                                word       <= shreg;
                                next_phase <= P_WDATA;
                            end
                            P_WDATA:
                            begin
                                sda_pull   <= 1'b1;
                                wr_pending <= 1'b1;
                                wr_addr    <= {blk, word};
                                wr_data    <= shreg;
                                next_phase <= P_IGNORE;
                            end
                            default:
                            begin
                                sda_pull   <= 1'b0;
                                next_phase <= P_IGNORE;
                            end
                        endcase
                    end
                end
                else
                begin
                    // end of the ack slot
                    bit_cnt <= '0;
                    phase   <= next_phase;
                    if (next_phase == P_READ)
                    begin
                        sending  <= 1'b1;
                        tx       <= mem[{blk, word}];
                        sda_pull <= !mem[{blk, word}][DATA_W-1];
                    end
                    else
                    begin
                        sending  <= 1'b0;
                        sda_pull <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD       = 4.0,
    parameter int  RESET_CYCLES = 3
) (
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD / 2.0) CLK = ~CLK;
    end

    initial
    begin
        RESET = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        RESET <= 1'b0;
    end

endmodule

// File: verif/tb_eeprom_master.sv
`timescale 1ns/1ps

module tb_eeprom_master;
    import eeprom_cmd_pkg::*;

    localparam int MEM_SIZE   = 2048;
    localparam int N_TXN      = 40;
    localparam int WAIT_LIMIT = 4000;

    logic              CLK;
    logic              RESET;
    logic              req;
    eeprom_op_e        op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              ready;
    logic              done;
    logic [DATA_W-1:0] rdata;
    logic              nack_err;
    logic              scl;
    logic              sda_oe;
    logic              sda;
    logic              slave_pull;
    logic              nack_mode;
    logic              proto_err;

    logic [DATA_W-1:0] ref_mem [0:MEM_SIZE-1];
    logic [31:0]       rng;
    int                done_cnt;
    int                req_cnt;

    tb_clock #(.PERIOD(4.0), .RESET_CYCLES(3)) clk0 (.CLK(CLK), .RESET(RESET));

    eeprom_master_top #(.CLK_DIV(4)) dut0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .op       (op),
        .addr     (addr),
        .wdata    (wdata),
        .ready    (ready),
        .done     (done),
        .rdata    (rdata),
        .nack_err (nack_err),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda)
    );

    eeprom_slave_model slave0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda),
        .nack_mode (nack_mode),
        .sda_pull  (slave_pull),
        .proto_err (proto_err)
    );

    assign sda = !(sda_oe || slave_pull);   // wired-AND of both pull-lows

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s got %02h expected %02h",
                               $time, what, got, exp));
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b",
                               $time, what, got, exp));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(negedge CLK)
    begin
        if (!RESET && proto_err === 1'b1)
            fail_run("bus protocol violation seen by the slave model");
    end

    // every done pulse the DUT gives
    always @(posedge CLK)
    begin
        if (RESET)
            done_cnt <= 0;
        else if (done === 1'b1)
            done_cnt <= done_cnt + 1;
    end

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge CLK);
        while (ready !== 1'b1)
        begin
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT)
                fail_run("timeout while waiting for ready");
        end
    endtask

    // one host request, with stray req pulses while busy
    task automatic run_txn(input eeprom_op_e t_op, input logic [ADDR_W-1:0] t_addr,
                           input logic [DATA_W-1:0] t_wdata, input logic exp_nack);
        int          n;
        logic        seen;
        logic        inject;
        logic [DATA_W-1:0] got_rdata;
        logic        got_nack;
        n    = 0;
        seen = 1'b0;
        wait_ready();
        if (done_cnt != req_cnt)
            fail_run("done pulse without an accepted request");
        @(posedge CLK);
        req   <= 1'b1;
        op    <= t_op;
        addr  <= t_addr;
        wdata <= t_wdata;
        @(posedge CLK);
        req <= 1'b0;
        req_cnt++;
        while (!seen)
        begin
            @(negedge CLK);
            if (n == 0)
                check_flag("ready after accept", ready, 1'b0);
            inject = 1'b0;
            if (done === 1'b1)
            begin
                seen      = 1'b1;
                got_rdata = rdata;
                got_nack  = nack_err;
            end
            else if ((n == 5 || n == 40) && ready === 1'b0)
                inject = 1'b1;
            n++;
            if (n > WAIT_LIMIT)
                fail_run("timeout while waiting for done");
            @(posedge CLK);
            req <= inject;
            if (inject)
            begin
                // stray request with different fields
                op    <= (t_op == OP_READ) ? OP_WRITE : OP_READ;
                addr  <= ~t_addr;
                wdata <= ~t_wdata;
            end
        end
        req <= 1'b0;
        check_flag("nack_err", got_nack, exp_nack);
        if (t_op == OP_READ && !exp_nack)
            check_byte($sformatf("rdata at %03h", t_addr), got_rdata, ref_mem[t_addr]);
        if (t_op == OP_WRITE && !exp_nack)
            ref_mem[t_addr] = t_wdata;
        // no second done before ready returns
        n = 0;
        @(negedge CLK);
        while (ready !== 1'b1)
        begin
            if (done === 1'b1)
                fail_run("second done pulse for a single request");
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT)
                fail_run("timeout while waiting for ready after done");
        end
        if (done_cnt != req_cnt)
            fail_run("more than one done pulse for a single request");
    endtask

    initial
    begin
        int                n;
        logic [ADDR_W-1:0] a;
        req       = 1'b0;
        op        = OP_WRITE;
        addr      = '0;
        wdata     = '0;
        nack_mode = 1'b0;
        rng       = 32'h0c80d6b2;
        req_cnt   = 0;
        for (int i = 0; i < MEM_SIZE; i++)
            ref_mem[i] = i[7:0] ^ 8'h5a;

        n = 0;
        @(negedge CLK);
        while (RESET !== 1'b0)
        begin
            @(negedge CLK);
            n++;
            if (n > 100)
                fail_run("reset never released");
        end

        repeat (8)
        begin
            @(negedge CLK);
            check_flag("ready after reset", ready, 1'b1);
            check_flag("scl after reset", scl, 1'b1);
            check_flag("sda_oe after reset", sda_oe, 1'b0);
        end

        run_txn(OP_READ, 11'h7ff, 8'h00, 1'b0);   // untouched
        run_txn(OP_READ, 11'h123, 8'h00, 1'b0);

        for (int t = 0; t < N_TXN; t++)
        begin
            rng = xorshift(rng);
            a   = {rng[10:8], 4'b0000, rng[3:0]};
            run_txn(rng[16] ? OP_READ : OP_WRITE, a, rng[31:24], 1'b0);
        end

        // slave stays silent on control bytes
        a = 11'h40a;
        @(posedge CLK);
        nack_mode <= 1'b1;
        run_txn(OP_WRITE, a, ~ref_mem[a], 1'b1);
        run_txn(OP_READ, a, 8'h00, 1'b1);
        @(posedge CLK);
        nack_mode <= 1'b0;
        run_txn(OP_READ, a, 8'h00, 1'b0);

        // stray req pulses of the last request must not start a transfer
        repeat (16)
        begin
            @(negedge CLK);
            if (ready !== 1'b1 || done_cnt != req_cnt)
                fail_run("transfer started without an accepted request");
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: verilog/byte_shifter.sv
`timescale 1ns/1ps

module byte_shifter (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              byte_go,
    input  logic                              byte_rd,
    input  logic [eeprom_cmd_pkg::DATA_W-1:0] tx_byte,
    input  logic                              master_nack,
    input  logic                              low_mid,
    input  logic                              high_mid,
    input  logic                              sda_in,
    output logic                              drive_low,
    output logic                              byte_done,
    output logic [eeprom_cmd_pkg::DATA_W-1:0] rx_byte,
    output logic                              ack_ok
);
    import eeprom_cmd_pkg::*;

    localparam int CNT_W = $clog2(DATA_W + 1);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_W - 1);
    localparam logic [CNT_W-1:0] ACK_SLOT = CNT_W'(DATA_W);

    logic              busy;
    logic              rd_mode;
    logic              nack_r;
    logic [CNT_W-1:0]  bit_cnt;
    logic [DATA_W-1:0] shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            rd_mode   <= 1'b0;
            nack_r    <= 1'b0;
            bit_cnt   <= '0;
            drive_low <= 1'b0;
            ack_ok    <= 1'b0;
        end
        else
        begin
            if (byte_go)
            begin
                busy      <= 1'b1;
                rd_mode   <= byte_rd;
                nack_r    <= master_nack;
                bit_cnt   <= '0;
                drive_low <= !byte_rd && !tx_byte[DATA_W-1];  // msb goes out now
            end
            else if (busy && low_mid)
            begin
                if (bit_cnt == ACK_SLOT)
                begin
                    busy      <= 1'b0;
                    drive_low <= 1'b0;
                end
                else if (bit_cnt == LAST_BIT)
                begin
                    bit_cnt   <= bit_cnt + 1'b1;
                    drive_low <= rd_mode && !nack_r;      // master ack on reads only
                end
                else
                begin
                    bit_cnt   <= bit_cnt + 1'b1;
                    drive_low <= !rd_mode && !shreg[DATA_W-2];
                end
            end

            if (busy && high_mid && bit_cnt == ACK_SLOT)
                ack_ok <= !sda_in;      // slave pulled the line low
        end
    end

    always_ff @(posedge CLK)
    begin
        if (byte_go)
            shreg <= tx_byte;
        else if (busy && low_mid)
            shreg <= shreg << 1;

        if (busy && high_mid && bit_cnt != ACK_SLOT)
            rx_byte <= {rx_byte[DATA_W-2:0], sda_in};
    end

    assign byte_done = busy && low_mid && (bit_cnt == ACK_SLOT);

    // sda must only move in the middle of scl low
    a_drive_on_low_mid: assert property (@(posedge CLK) disable iff (RESET)
        $changed(drive_low) |-> $past(low_mid));

    // controller chains bytes on the strobe itself
    a_go_on_low_mid: assert property (@(posedge CLK) disable iff (RESET)
        byte_go |-> low_mid);

endmodule

// File: verilog/cond_gen.sv
`timescale 1ns/1ps

module cond_gen (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               cond_go,
    input  i2c_bus_pkg::cond_e cond_kind,
    input  logic               low_mid,
    input  logic               high_mid,
    output logic               drive_low,
    output logic               cond_done
);
    import i2c_bus_pkg::*;

    typedef enum logic [2:0] {
        C_IDLE,
        C_START_WAIT,
        C_START_HOLD,
        C_STOP_LOW,
        C_STOP_HIGH,
        C_STOP_END
    } cstate_e;

    cstate_e state;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= C_IDLE;
            drive_low <= 1'b0;
        end
        else
        begin
            case (state)
                C_IDLE:
                    if (cond_go && cond_kind != COND_STOP)
                    begin
                        state <= C_START_WAIT;   // sda stays released until scl is high
                    end
                    else if (cond_go && low_mid)
                    begin
                        state     <= C_STOP_HIGH;  // stop right behind a byte
                        drive_low <= 1'b1;
                    end
                    else if (cond_go)
                    begin
                        state <= C_STOP_LOW;
                    end
                C_START_WAIT:
                    if (high_mid)
                    begin
                        state     <= C_START_HOLD;
                        drive_low <= 1'b1;       // falling sda with scl high
                    end
                C_START_HOLD:
                    if (low_mid)
                    begin
                        state     <= C_IDLE;
                        drive_low <= 1'b0;       // byte_shifter takes over here
                    end
                C_STOP_LOW:
                    if (low_mid)
                    begin
                        state     <= C_STOP_HIGH;
                        drive_low <= 1'b1;
                    end
                C_STOP_HIGH:
                    if (high_mid)
                    begin
                        state     <= C_STOP_END;
                        drive_low <= 1'b0;       // rising sda with scl high
                    end
                C_STOP_END:
                    if (low_mid)
                    begin
                        state <= C_IDLE;
                    end
                default:
                    state <= C_IDLE;
            endcase
        end
    end

    assign cond_done = low_mid && (state == C_START_HOLD || state == C_STOP_END);

    // controller must wait for cond_done before asking again
    a_go_while_busy: assert property (@(posedge CLK) disable iff (RESET)
        cond_go |-> state == C_IDLE);

endmodule

// File: verilog/eeprom_cmd_pkg.sv
package eeprom_cmd_pkg;

    // 24C16 byte address, 2 kB array
    localparam int ADDR_W = 11;

    localparam int DATA_W = 8;

    // fixed upper nibble of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // host request kind
    typedef enum logic {
        OP_WRITE,
        OP_READ
    } eeprom_op_e;

endpackage

// File: verilog/eeprom_ctrl.sv
`timescale 1ns/1ps

module eeprom_ctrl (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              req,
    input  eeprom_cmd_pkg::eeprom_op_e        op,
    input  logic [eeprom_cmd_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_cmd_pkg::DATA_W-1:0] wdata,
    output logic                              ready,
    output logic                              done,
    output logic [eeprom_cmd_pkg::DATA_W-1:0] rdata,
    output logic                              nack_err,
    output logic                              scl_run,
    output logic                              cond_go,
    output i2c_bus_pkg::cond_e                cond_kind,
    input  logic                              cond_done,
    output logic                              byte_go,
    output logic                              byte_rd,
    output logic [eeprom_cmd_pkg::DATA_W-1:0] tx_byte,
    output logic                              master_nack,
    input  logic                              byte_done,
    input  logic [eeprom_cmd_pkg::DATA_W-1:0] rx_byte,
    input  logic                              ack_ok,
    input  logic                              cond_drive_low,
    input  logic                              byte_drive_low,
    output logic                              sda_oe
);
    import eeprom_cmd_pkg::*;
    import i2c_bus_pkg::*;

    typedef enum logic [3:0] {
        IDLE, START, CTRL_W, ADDR, WDATA, RESTART, CTRL_R, RDATA, STOP, DONE
    } state_e;

    state_e            state;
    state_e            next;
    sda_src_e          sda_src;
    eeprom_op_e        op_r;
    logic [ADDR_W-1:0] addr_r;
    logic [DATA_W-1:0] wdata_r;
    logic [DATA_W-1:0] ctrl_byte_w;
    logic [DATA_W-1:0] ctrl_byte_r;
    logic              accept;
    logic              ack_miss;
    logic              err_r;

    assign accept   = (state == IDLE) && req;
    assign ack_miss = byte_done && !ack_ok && (state != RDATA);   // rdata ends in our nack

    assign ctrl_byte_w = {DEVICE_CODE, addr_r[ADDR_W-1:DATA_W], 1'b0};
    assign ctrl_byte_r = {DEVICE_CODE, addr_r[ADDR_W-1:DATA_W], 1'b1};

    // go strobes are decoded on the done strobe so the next step starts on the same low_mid
    always_comb
    begin
        next        = state;
        cond_go     = 1'b0;
        cond_kind   = COND_START;
        byte_go     = 1'b0;
        byte_rd     = 1'b0;
        master_nack = 1'b0;
        tx_byte     = ctrl_byte_w;
        case (state)
            IDLE:
                if (req)
                begin
                    next    = START;
                    cond_go = 1'b1;
                end
            START:
                if (cond_done)
                begin
                    next    = CTRL_W;
                    byte_go = 1'b1;
                end
            CTRL_W:
                if (byte_done)
                begin
                    next    = ADDR;
                    byte_go = 1'b1;
                    tx_byte = addr_r[DATA_W-1:0];
                end
            ADDR:
                if (byte_done && op_r == OP_WRITE)
                begin
                    next    = WDATA;
                    byte_go = 1'b1;
                    tx_byte = wdata_r;
                end
                else if (byte_done)
                begin
                    next      = RESTART;
                    cond_go   = 1'b1;
                    cond_kind = COND_RESTART;
                end
            RESTART:
                if (cond_done)
                begin
                    next    = CTRL_R;
                    byte_go = 1'b1;
                    tx_byte = ctrl_byte_r;
                end
            CTRL_R:
                if (byte_done)
                begin
                    next        = RDATA;
                    byte_go     = 1'b1;
                    byte_rd     = 1'b1;
                    master_nack = 1'b1;    // single byte read
                end
            WDATA, RDATA:
                if (byte_done)
                begin
                    next      = STOP;
                    cond_go   = 1'b1;
                    cond_kind = COND_STOP;
                end
            STOP:
                if (cond_done)
                    next = DONE;
            DONE:
                next = IDLE;
            default:
                next = IDLE;
        endcase

        // no acknowledge, abandon the sequence
        if (ack_miss)
        begin
            next      = STOP;
            byte_go   = 1'b0;
            cond_go   = 1'b1;
            cond_kind = COND_STOP;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= IDLE;
            scl_run <= 1'b0;
            err_r   <= 1'b0;
        end
        else
        begin
            state <= next;
            if (accept)
            begin
                scl_run <= 1'b1;
                err_r   <= 1'b0;
            end
            else if (state == STOP && cond_done)
            begin
                scl_run <= 1'b0;     // scl parks high after this low phase
            end
            if (ack_miss)
                err_r <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op_r    <= op;
            addr_r  <= addr;
            wdata_r <= wdata;
        end
        if (state == RDATA && byte_done)
            rdata <= rx_byte;
    end

    assign ready    = (state == IDLE);
    assign done     = (state == DONE);
    assign nack_err = done && err_r;

    always_comb
    begin
        case (state)
            START, RESTART, STOP:
                sda_src = SRC_COND;
            CTRL_W, ADDR, WDATA, CTRL_R, RDATA:
                sda_src = SRC_BYTE;
            default:
                sda_src = SRC_NONE;
        endcase
    end

    always_comb
    begin
        case (sda_src)
            SRC_COND: sda_oe = cond_drive_low;
            SRC_BYTE: sda_oe = byte_drive_low;
            default:  sda_oe = 1'b0;
        endcase
    end

    // host side rule, a req while busy is dropped
    a_req_while_busy: assert property (@(posedge CLK) disable iff (RESET)
        req |-> ready)
        else $warning("req ignored while controller busy");

endmodule

// File: verilog/eeprom_master_top.sv
`timescale 1ns/1ps

module eeprom_master_top #(
    parameter int CLK_DIV = 4   // clk cycles per scl half period
) (
    input  logic                              CLK,
    input  logic                              RESET,
    input  logic                              req,
    input  eeprom_cmd_pkg::eeprom_op_e        op,
    input  logic [eeprom_cmd_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_cmd_pkg::DATA_W-1:0] wdata,
    output logic                              ready,
    output logic                              done,
    output logic [eeprom_cmd_pkg::DATA_W-1:0] rdata,
    output logic                              nack_err,
    output logic                              scl,
    output logic                              sda_oe,
    input  logic                              sda_in
);
    import eeprom_cmd_pkg::*;
    import i2c_bus_pkg::*;

    logic              scl_run;
    logic              low_mid;
    logic              high_mid;
    logic              cond_go;
    cond_e             cond_kind;
    logic              cond_done;
    logic              cond_drive_low;
    logic              byte_go;
    logic              byte_rd;
    logic [DATA_W-1:0] tx_byte;
    logic              master_nack;
    logic              byte_done;
    logic [DATA_W-1:0] rx_byte;
    logic              ack_ok;
    logic              byte_drive_low;

    eeprom_ctrl ctrl0 (
        .CLK            (CLK),
        .RESET          (RESET),
        .req            (req),
        .op             (op),
        .addr           (addr),
        .wdata          (wdata),
        .ready          (ready),
        .done           (done),
        .rdata          (rdata),
        .nack_err       (nack_err),
        .scl_run        (scl_run),
        .cond_go        (cond_go),
        .cond_kind      (cond_kind),
        .cond_done      (cond_done),
        .byte_go        (byte_go),
        .byte_rd        (byte_rd),
        .tx_byte        (tx_byte),
        .master_nack    (master_nack),
        .byte_done      (byte_done),
        .rx_byte        (rx_byte),
        .ack_ok         (ack_ok),
        .cond_drive_low (cond_drive_low),
        .byte_drive_low (byte_drive_low),
        .sda_oe         (sda_oe)
    );

    scl_gen #(
        .CLK_DIV (CLK_DIV)
    ) scl0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl_run  (scl_run),
        .scl      (scl),
        .low_mid  (low_mid),
        .high_mid (high_mid)
    );

    cond_gen cond0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .cond_go   (cond_go),
        .cond_kind (cond_kind),
        .low_mid   (low_mid),
        .high_mid  (high_mid),
        .drive_low (cond_drive_low),
        .cond_done (cond_done)
    );

    byte_shifter shift0 (
        .CLK         (CLK),
        .RESET       (RESET),
        .byte_go     (byte_go),
        .byte_rd     (byte_rd),
        .tx_byte     (tx_byte),
        .master_nack (master_nack),
        .low_mid     (low_mid),
        .high_mid    (high_mid),
        .sda_in      (sda_in),
        .drive_low   (byte_drive_low),
        .byte_done   (byte_done),
        .rx_byte     (rx_byte),
        .ack_ok      (ack_ok)
    );

endmodule

// File: verilog/i2c_bus_pkg.sv
package i2c_bus_pkg;

    // condition the controller asks cond_gen for
    typedef enum logic [1:0] {
        COND_START,
        COND_RESTART,   // start without a stop before it
        COND_STOP
    } cond_e;

    // which block currently owns the sda pull-low
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_COND,
        SRC_BYTE
    } sda_src_e;

endpackage

// File: verilog/scl_gen.sv
`timescale 1ns/1ps

module scl_gen #(
    parameter int CLK_DIV = 4   // clk cycles per scl half period, 2 or more
) (
    input  logic CLK,
    input  logic RESET,
    input  logic scl_run,
    output logic scl,
    output logic low_mid,
    output logic high_mid
);

    localparam int CNT_W = $clog2(CLK_DIV);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLK_DIV - 1);
    localparam logic [CNT_W-1:0] MID  = CNT_W'(CLK_DIV / 2);

    logic [CNT_W-1:0] cnt;
    logic             parked;

    // only a high scl can park, so a running low phase always completes
    assign parked = scl && !scl_run;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl <= 1'b1;
            cnt <= '0;
        end
        else if (parked)
        begin
            cnt <= '0;
        end
        else if (cnt == LAST)
        begin
            cnt <= '0;
            scl <= ~scl;        // phase boundary
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    assign low_mid  = !scl && (cnt == MID);
    assign high_mid = scl && scl_run && (cnt == MID);

endmodule
